//--- compile.f
+incdir+verilog
verilog/axi_bridge_pkg.sv
verilog/axi_burst_counter.sv
verilog/axi_sub_fsm.sv
verilog/mem_fwd_packer.sv
verilog/mem_rev_unpacker.sv
verilog/axi_mem_bridge.sv
tests/tb_axi_mem_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the AXI bridge testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  -f compile.f \
  --top-module tb_axi_mem_bridge \
  --Mdir obj_dir \
  -o tb_axi_mem_bridge

./obj_dir/tb_axi_mem_bridge | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

//--- tests/tb_axi_mem_bridge.sv
/* runs the transaction table twice, first with no stalls, then with random stalls and latency;
   the memory model serves one forward message at a time and flags a fixed bad address range. */

`timescale 1ns/1ps

`include "axi_bridge_cfg.svh"

module tb_axi_mem_bridge
  import axi_bridge_pkg::*;
();

  localparam int          n_entry = 12;
  localparam int          n_round = 2;
  localparam logic [31:0] seed    = 32'h8be3_3b8e;
  localparam logic [31:0] bad_lo  = 32'h0000_2010;
  localparam logic [31:0] bad_hi  = 32'h0000_2020;  // exclusive.

  typedef enum logic [1:0] {kind_wr, kind_rd, kind_wr_rd} kind_e;

  typedef struct {
    kind_e       kind;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [3:0]  id;
    logic [31:0] data_seed;
    logic [7:0]  strb;
  } entry_s;

  logic                   clk;
  logic                   rst_n;
  axi_ax_s                aw;
  axi_ax_s                ar;
  logic                   aw_valid, aw_ready, ar_valid, ar_ready;
  logic [`AXI_DATA_W-1:0] w_data;
  logic [`AXI_STRB_W-1:0] w_strb;
  logic                   w_last, w_valid, w_ready;
  logic [`AXI_ID_W-1:0]   b_id, r_id;
  logic [1:0]             b_resp, r_resp;
  logic                   b_valid, b_ready;
  logic [`AXI_DATA_W-1:0] r_data;
  logic                   r_last, r_valid, r_ready;
  mem_fwd_s               mem_fwd;
  logic                   mem_fwd_v, mem_fwd_ready;
  mem_rev_s               mem_rev;
  logic                   mem_rev_v, mem_rev_ready;

  entry_s      table_q [n_entry];
  logic [63:0] mem_data [logic [31:0]];     // memory model contents, by beat address.
  logic [63:0] ref_data [logic [31:0]];     // expected contents.
  logic [31:0] fwd_addr_q [$];              // every forward message seen, in order.
  mem_msg_e    fwd_type_q [$];
  logic [2:0]  fwd_size_q [$];
  longint      ar_hs_q [$];                 // time of every AR handshake.
  logic [31:0] rng_axi, rng_mem;
  logic        stall_en;
  int          err_cnt, ent_pass, ent_fail;
  longint      wd_limit;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  axi_mem_bridge dut0 (
    .clk_i(clk), .rst_n_i(rst_n),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_data_i(w_data), .w_strb_i(w_strb), .w_last_i(w_last), .w_valid_i(w_valid),
    .w_ready_o(w_ready),
    .b_id_o(b_id), .b_resp_o(b_resp), .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_data_o(r_data), .r_id_o(r_id), .r_resp_o(r_resp), .r_last_o(r_last),
    .r_valid_o(r_valid), .r_ready_i(r_ready),
    .mem_fwd_o(mem_fwd), .mem_fwd_v_o(mem_fwd_v), .mem_fwd_ready_i(mem_fwd_ready),
    .mem_rev_i(mem_rev), .mem_rev_v_i(mem_rev_v), .mem_rev_ready_o(mem_rev_ready)
  );

  always @(posedge clk) begin
    if (ar_valid && ar_ready) ar_hs_q.push_back($time);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // unwritten memory reads back its own address.
  function automatic logic [63:0] fill_word(input logic [31:0] a);
    return {a ^ 32'h5a5a_a5a5, a};
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] strb);
    logic [63:0] m;
    for (int k = 0; k < 8; k++) begin
      m[k*8 +: 8] = {8{strb[k]}};
    end
    return m;
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] s, input int i);
    return {s ^ 32'(i), xorshift(s + 32'(i))};
  endfunction

  function automatic logic in_bad(input logic [31:0] a);
    return (a >= bad_lo) && (a < bad_hi);
  endfunction

  function automatic logic [63:0] mem_read(input logic [31:0] a);
    return mem_data.exists(a) ? mem_data[a] : fill_word(a);
  endfunction

  function automatic logic [63:0] ref_read(input logic [31:0] a);
    return ref_data.exists(a) ? ref_data[a] : fill_word(a);
  endfunction

  function automatic axi_ax_s make_ax(input logic [31:0] addr, input logic [3:0] id,
                                      input logic [7:0] len);
    axi_ax_s ax;
    ax.addr  = addr;
    ax.id    = id;
    ax.len   = len;
    ax.size  = 3'd3;
    ax.burst = 2'b01;                         // INCR.
    return ax;
  endfunction

  function automatic entry_s make_entry(input kind_e kind, input logic [31:0] addr,
                                        input logic [7:0] len, input logic [3:0] id,
                                        input logic [31:0] data_seed, input logic [7:0] strb);
    entry_s e;
    e.kind      = kind;
    e.addr      = addr;
    e.len       = len;
    e.id        = id;
    e.data_seed = data_seed;
    e.strb      = strb;
    return e;
  endfunction

  task automatic load_table();
    table_q[0]  = make_entry(kind_wr,    32'h0000_0100, 8'd0,  4'd3,  32'h1357_0001, 8'hff);
    table_q[1]  = make_entry(kind_rd,    32'h0000_0100, 8'd0,  4'd5,  32'h0,         8'h00);
    table_q[2]  = make_entry(kind_wr,    32'h0000_0400, 8'd3,  4'd1,  32'h1357_0002, 8'hff);
    table_q[3]  = make_entry(kind_rd,    32'h0000_0400, 8'd3,  4'd2,  32'h0,         8'h00);
    table_q[4]  = make_entry(kind_wr,    32'h0000_0408, 8'd1,  4'd6,  32'h1357_0003, 8'h5a);
    table_q[5]  = make_entry(kind_rd,    32'h0000_03f8, 8'd5,  4'd7,  32'h0,         8'h00);
    table_q[6]  = make_entry(kind_wr,    32'h0000_2000, 8'd3,  4'd8,  32'h1357_0004, 8'hff);
    table_q[7]  = make_entry(kind_rd,    32'h0000_2000, 8'd3,  4'd9,  32'h0,         8'h00);
    table_q[8]  = make_entry(kind_wr_rd, 32'h0000_0800, 8'd1,  4'd10, 32'h1357_0005, 8'hf0);
    table_q[9]  = make_entry(kind_wr,    32'h0000_1000, 8'd15, 4'd11, 32'h1357_0006, 8'hff);
    table_q[10] = make_entry(kind_rd,    32'h0000_1000, 8'd15, 4'd12, 32'h0,         8'h00);
    table_q[11] = make_entry(kind_wr_rd, 32'h0000_2008, 8'd2,  4'd13, 32'h1357_0007, 8'h0f);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic next_ready(inout logic [31:0] st, output logic rdy);
    st  = xorshift(st);
    rdy = !stall_en || (st[1:0] != 2'b00);    // ready three cycles in four.
  endtask

  // called at a falling edge, returns at one.
  task automatic send_beats(input entry_s e);
    logic [31:0] a;
    logic [63:0] m;
    m = byte_mask(e.strb);
    for (int i = 0; i <= int'(e.len); i++) begin
      a       = e.addr + 32'(i * 8);
      w_data  = beat_data(e.data_seed, i);
      w_strb  = e.strb;
      w_last  = (i == int'(e.len));
      w_valid = 1'b1;
      do begin
        @(posedge clk);
      end while (!w_ready);
      ref_data[a] = (ref_read(a) & ~m) | (w_data & m);
      @(negedge clk);
    end
    w_valid = 1'b0;
    w_last  = 1'b0;
  endtask

  task automatic take_b(input entry_s e, output longint t_b);
    logic       rdy;
    logic       done;
    logic       any_bad;
    logic [3:0] id_s;
    logic [1:0] resp_s;
    any_bad = 1'b0;
    for (int i = 0; i <= int'(e.len); i++) begin
      any_bad = any_bad | in_bad(e.addr + 32'(i * 8));
    end
    t_b = 0;
    do begin
      next_ready(rng_axi, rdy);
      b_ready = rdy;
      @(posedge clk);
      done   = b_valid && b_ready;
      id_s   = b_id;
      resp_s = b_resp;
      if (done) t_b = $time;
      @(negedge clk);
    end while (!done);
    b_ready = 1'b0;
    check_value("b_id", 64'(id_s), 64'(e.id));
    check_value("b_resp", 64'(resp_s), any_bad ? 64'(`RESP_SLVERR) : 64'(`RESP_OKAY));
  endtask

  task automatic take_r(input entry_s e, input logic [3:0] id);
    logic [31:0] a;
    logic        rdy;
    logic        done;
    logic [63:0] data_s;
    logic [3:0]  id_s;
    logic [1:0]  resp_s;
    logic        last_s;
    for (int i = 0; i <= int'(e.len); i++) begin
      a = e.addr + 32'(i * 8);
      do begin
        next_ready(rng_axi, rdy);
        r_ready = rdy;
        @(posedge clk);
        done   = r_valid && r_ready;
        data_s = r_data;
        id_s   = r_id;
        resp_s = r_resp;
        last_s = r_last;
        @(negedge clk);
      end while (!done);
      check_value("r_data", data_s, ref_read(a));
      check_value("r_resp", 64'(resp_s), in_bad(a) ? 64'(`RESP_SLVERR) : 64'(`RESP_OKAY));
      check_value("r_id", 64'(id_s), 64'(id));
      check_value("r_last", 64'(last_s), 64'(i == int'(e.len)));
    end
    r_ready = 1'b0;
  endtask

  task automatic run_entry(input entry_s e);
    longint     t_b;
    logic [3:0] rd_id;
    int         base;
    int         ar_base;
    int         n_beat;
    int         n_exp;
    int         j;
    logic       exp_wr;
    rd_id   = (e.kind == kind_wr_rd) ? ~e.id : e.id;
    base    = fwd_addr_q.size();
    ar_base = ar_hs_q.size();
    n_beat  = int'(e.len) + 1;
    n_exp   = (e.kind == kind_wr_rd) ? 2 * n_beat : n_beat;
    t_b     = 0;
    if (e.kind != kind_rd) begin
      aw       = make_ax(e.addr, e.id, e.len);
      aw_valid = 1'b1;
    end
    if (e.kind != kind_wr) begin
      ar       = make_ax(e.addr, rd_id, e.len);
      ar_valid = 1'b1;                        // stays up through a same-cycle write.
    end
    if (e.kind != kind_rd) begin
      do begin
        @(posedge clk);
      end while (!aw_ready);
      @(negedge clk);
      aw_valid = 1'b0;
      send_beats(e);
      take_b(e, t_b);
    end
    if (e.kind != kind_wr) begin
      do begin
        @(posedge clk);
      end while (!ar_ready);
      @(negedge clk);
      ar_valid = 1'b0;
      take_r(e, rd_id);
    end
    if (e.kind == kind_wr_rd) begin
      check_value("ar accepted after b", 64'(ar_hs_q[ar_base] > t_b), 64'd1);
    end
    // one forward message per beat, 8 bytes apart, writes first.
    check_value("forward beat count", 64'(fwd_addr_q.size() - base), 64'(n_exp));
    for (int k = 0; k < n_exp && base + k < fwd_addr_q.size(); k++) begin
      j      = k % n_beat;
      exp_wr = (e.kind == kind_wr) || (e.kind == kind_wr_rd && k < n_beat);
      check_value("mem_fwd addr", 64'(fwd_addr_q[base + k]), 64'(e.addr + 32'(j * 8)));
      check_value("mem_fwd msg_type", 64'(fwd_type_q[base + k] == e_mem_uc_wr), 64'(exp_wr));
      check_value("mem_fwd size", 64'(fwd_size_q[base + k]), 64'(3'd3));
    end
  endtask

  initial begin : mem_model
    mem_fwd_s    req;
    mem_rev_s    rsp;
    logic [63:0] m;
    logic        rdy;
    int          lat;
    mem_fwd_ready = 1'b0;
    mem_rev_v     = 1'b0;
    mem_rev       = '0;
    rng_mem       = xorshift(seed);
    forever begin
      @(negedge clk);
      mem_rev_v = 1'b0;
      next_ready(rng_mem, rdy);
      mem_fwd_ready = rdy;
      @(posedge clk);
      if (mem_fwd_v && mem_fwd_ready) begin
        req = mem_fwd;
        fwd_addr_q.push_back(req.addr);
        fwd_type_q.push_back(req.msg_type);
        fwd_size_q.push_back(req.size);
        rsp.msg_type = req.msg_type;
        rsp.err      = in_bad(req.addr);    // data still moves on an errored beat.
        rsp.data     = '0;
        if (req.msg_type == e_mem_uc_wr) begin
          m = byte_mask(req.mask);
          mem_data[req.addr] = (mem_read(req.addr) & ~m) | (req.data & m);
        end else begin
          rsp.data = mem_read(req.addr);
        end
        rng_mem = xorshift(rng_mem);
        lat     = stall_en ? int'(rng_mem % 32'd6) : 0;
        @(negedge clk);
        mem_fwd_ready = 1'b0;
        repeat (lat) @(negedge clk);
        mem_rev   = rsp;
        mem_rev_v = 1'b1;
        do begin
          @(posedge clk);
        end while (!mem_rev_ready);
      end
    end
  end

  initial begin : watchdog
    wait (wd_limit != 0);
    #(wd_limit);
    $display("watchdog: the transaction table did not finish within %0d ns", wd_limit);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    entry_s e;
    int     beats;
    int     errs;
    rst_n    = 1'b0;
    aw       = '0;
    ar       = '0;
    aw_valid = 1'b0;
    ar_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    rng_axi  = seed;
    stall_en = 1'b0;
    err_cnt  = 0;
    ent_pass = 0;
    ent_fail = 0;
    load_table();
    beats = 0;
    for (int k = 0; k < n_entry; k++) begin
      beats += (int'(table_q[k].len) + 1) * ((table_q[k].kind == kind_wr_rd) ? 2 : 1);
    end
    wd_limit = longint'(beats * n_round * 200 + 8 * 8);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int p = 0; p < n_round; p++) begin
      stall_en = (p == 1);
      for (int k = 0; k < n_entry; k++) begin
        e           = table_q[k];
        e.data_seed = e.data_seed ^ 32'(p);   // fresh data in the second round.
        errs        = err_cnt;
        run_entry(e);
        if (err_cnt == errs) begin
          ent_pass++;
          $display("round %0d entry %0d %s addr 0x%h: ok", p, k, e.kind.name(), e.addr);
        end else begin
          ent_fail++;
          $display("round %0d entry %0d %s addr 0x%h: %0d mismatches", p, k,
                   e.kind.name(), e.addr, err_cnt - errs);
        end
      end
    end
    $display("entries passed %0d, failed %0d, mismatches %0d", ent_pass, ent_fail, err_cnt);
    if (ent_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog/axi_mem_bridge.sv
/* AXI4 subordinate to uncached memory messages; INCR only, 64-bit data,
   no lock/cache/prot/qos/region, and w_last_i is ignored in favour of len. */

`timescale 1ns/1ps

`include "axi_bridge_cfg.svh"

module axi_mem_bridge
  import axi_bridge_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_ax_s                aw_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic [`AXI_DATA_W-1:0] w_data_i,
  input  logic [`AXI_STRB_W-1:0] w_strb_i,
  input  logic                   w_last_i,   // unused, beat count comes from len.
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output logic [`AXI_ID_W-1:0]   b_id_o,
  output logic [1:0]             b_resp_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  input  axi_ax_s                ar_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  output logic [`AXI_DATA_W-1:0] r_data_o,
  output logic [`AXI_ID_W-1:0]   r_id_o,
  output logic [1:0]             r_resp_o,
  output logic                   r_last_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output mem_fwd_s               mem_fwd_o,
  output logic                   mem_fwd_v_o,
  input  logic                   mem_fwd_ready_i,
  input  mem_rev_s               mem_rev_i,
  input  logic                   mem_rev_v_i,
  output logic                   mem_rev_ready_o
);

  logic                   cnt_load, cnt_step, beat_last;
  logic                   fwd_load, fwd_busy, rev_ready, rev_done, r_busy, err_clr;
  mem_msg_e               is_wr;
  axi_ax_s                ax_sel;
  logic [`AXI_ADDR_W-1:0] beat_addr;
  logic [`AXI_ID_W-1:0]   cur_id;
  logic [2:0]             cur_size;

  assign ax_sel = (is_wr == e_mem_uc_wr) ? aw_i : ar_i; // request that won arbitration.
  assign b_id_o = cur_id;
  assign r_id_o = cur_id;

  axi_sub_fsm u_fsm (
    .clk_i, .rst_n_i, .aw_valid_i, .ar_valid_i, .aw_ready_o, .ar_ready_o,
    .w_valid_i, .w_ready_o, .b_ready_i, .b_valid_o, .r_ready_i,
    .cnt_load_o(cnt_load), .cnt_step_o(cnt_step), .cnt_is_wr_o(is_wr),
    .beat_last_i(beat_last), .fwd_load_o(fwd_load), .fwd_busy_i(fwd_busy),
    .rev_ready_o(rev_ready), .rev_done_i(rev_done), .r_busy_i(r_busy),
    .err_clr_o(err_clr)
  );

  axi_burst_counter u_cnt (
    .clk_i, .rst_n_i, .load_i(cnt_load), .ax_i(ax_sel), .step_i(cnt_step),
    .addr_o(beat_addr), .id_o(cur_id), .size_o(cur_size), .last_o(beat_last)
  );

  mem_fwd_packer u_fwd (
    .clk_i, .rst_n_i, .load_i(fwd_load), .msg_type_i(is_wr), .addr_i(beat_addr),
    .size_i(cur_size), .data_i(w_data_i), .mask_i(w_strb_i), .busy_o(fwd_busy),
    .mem_fwd_o, .mem_fwd_v_o, .mem_fwd_ready_i
  );

  mem_rev_unpacker u_rev (
    .clk_i, .rst_n_i, .mem_rev_i, .mem_rev_v_i, .rev_ready_i(rev_ready),
    .mem_rev_ready_o, .last_i(beat_last), .err_clr_i(err_clr), .rev_done_o(rev_done),
    .r_data_o, .r_resp_o, .r_last_o, .r_valid_o, .r_ready_i, .r_busy_o(r_busy),
    .b_resp_o
  );

endmodule

//--- verilog/mem_rev_unpacker.sv
/* a single R register; write responses only update the sticky B error bit. */

`timescale 1ns/1ps

`include "axi_bridge_cfg.svh"

module mem_rev_unpacker
  import axi_bridge_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_rev_s               mem_rev_i,
  input  logic                   mem_rev_v_i,
  input  logic                   rev_ready_i,
  output logic                   mem_rev_ready_o,
  input  logic                   last_i,
  input  logic                   err_clr_i,
  output logic                   rev_done_o,
  output logic [`AXI_DATA_W-1:0] r_data_o,
  output logic [1:0]             r_resp_o,
  output logic                   r_last_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output logic                   r_busy_o,
  output logic [1:0]             b_resp_o
);

  logic [`AXI_DATA_W-1:0] r_data_q;
  logic [1:0]             r_resp_q;
  logic                   r_last_q;
  logic                   r_valid_q;
  logic                   err_q;             // any write beat failed.
  logic                   cap_rd;

  assign mem_rev_ready_o = rev_ready_i && !r_valid_q;
  assign rev_done_o      = mem_rev_v_i && mem_rev_ready_o;
  assign cap_rd          = rev_done_o && (mem_rev_i.msg_type == e_mem_uc_rd);

  always_ff @(posedge clk_i) begin
    if (cap_rd) begin
      r_data_q <= mem_rev_i.data;
      r_resp_q <= mem_rev_i.err ? `RESP_SLVERR : `RESP_OKAY;
      r_last_q <= last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      if (cap_rd) r_valid_q <= 1'b1;
      else if (r_ready_i) r_valid_q <= 1'b0;
      if (err_clr_i) err_q <= 1'b0;
      else if (rev_done_o && mem_rev_i.msg_type == e_mem_uc_wr) err_q <= err_q | mem_rev_i.err;
    end
  end

  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;
  assign r_last_o  = r_last_q;
  assign r_valid_o = r_valid_q;
  assign r_busy_o  = r_valid_q;
  assign b_resp_o  = err_q ? `RESP_SLVERR : `RESP_OKAY;

endmodule

//--- verilog/mem_fwd_packer.sv
/* holds one forward message; load_i must only come while busy_o is low. */

`timescale 1ns/1ps

`include "axi_bridge_cfg.svh"

module mem_fwd_packer
  import axi_bridge_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   load_i,
  input  mem_msg_e               msg_type_i,
  input  logic [`AXI_ADDR_W-1:0] addr_i,
  input  logic [2:0]             size_i,
  input  logic [`AXI_DATA_W-1:0] data_i,
  input  logic [`AXI_STRB_W-1:0] mask_i,
  output logic                   busy_o,
  output mem_fwd_s               mem_fwd_o,
  output logic                   mem_fwd_v_o,
  input  logic                   mem_fwd_ready_i
);

  mem_fwd_s msg_q;
  logic     v_q;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      msg_q.msg_type <= msg_type_i;
      msg_q.addr     <= addr_i;
      msg_q.size     <= size_i;
      msg_q.data     <= (msg_type_i == e_mem_uc_wr) ? data_i : '0; // reads carry no data.
      msg_q.mask     <= (msg_type_i == e_mem_uc_wr) ? mask_i : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_q <= 1'b0;
    end else if (load_i) begin
      v_q <= 1'b1;
    end else if (mem_fwd_ready_i) begin
      v_q <= 1'b0;                           // sent.
    end
  end

  assign mem_fwd_o   = msg_q;
  assign mem_fwd_v_o = v_q;
  assign busy_o      = v_q;

endmodule

//--- verilog/axi_sub_fsm.sv
/* one transaction at a time; AW wins over AR in the same idle cycle, and each
   beat waits for its reverse message before the next one is issued. */

`timescale 1ns/1ps

module axi_sub_fsm
  import axi_bridge_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     aw_valid_i,
  input  logic     ar_valid_i,
  output logic     aw_ready_o,
  output logic     ar_ready_o,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  input  logic     b_ready_i,
  output logic     b_valid_o,
  input  logic     r_ready_i,
  output logic     cnt_load_o,
  output logic     cnt_step_o,
  output mem_msg_e cnt_is_wr_o,
  input  logic     beat_last_i,
  output logic     fwd_load_o,
  input  logic     fwd_busy_i,
  output logic     rev_ready_o,
  input  logic     rev_done_i,
  input  logic     r_busy_i,
  output logic     err_clr_o
);

  bridge_state_e state_q, state_d;
  logic          fin_q;                      // last read beat returned.

  always_comb begin
    state_d     = state_q;
    aw_ready_o  = 1'b0;
    ar_ready_o  = 1'b0;
    w_ready_o   = 1'b0;
    b_valid_o   = 1'b0;
    cnt_load_o  = 1'b0;
    cnt_step_o  = 1'b0;
    fwd_load_o  = 1'b0;
    rev_ready_o = 1'b0;
    err_clr_o   = 1'b0;
    case (state_q)
      e_idle: begin
        aw_ready_o = 1'b1;
        ar_ready_o = !aw_valid_i;            // write has priority.
        if (aw_valid_i || ar_valid_i) begin
          cnt_load_o = 1'b1;
          err_clr_o  = 1'b1;
          state_d    = aw_valid_i ? e_wr_beat : e_rd_beat;
        end
      end
      e_wr_beat: begin
        w_ready_o = !fwd_busy_i;
        if (w_valid_i && !fwd_busy_i) begin
          fwd_load_o = 1'b1;
          state_d    = e_wr_wait;
        end
      end
      e_wr_wait: begin
        rev_ready_o = 1'b1;
        if (rev_done_i) begin
          cnt_step_o = !beat_last_i;
          state_d    = beat_last_i ? e_wr_resp : e_wr_beat;
        end
      end
      e_wr_resp: begin
        b_valid_o = 1'b1;
        if (b_ready_i) state_d = e_idle;
      end
      e_rd_beat: begin
        // the R beat must leave before the id can change or a new beat starts.
        if (fin_q && !r_busy_i) begin
          state_d = e_idle;
        end else if (!fin_q && !r_busy_i && !fwd_busy_i) begin
          fwd_load_o = 1'b1;
          state_d    = e_rd_wait;
        end
      end
      e_rd_wait: begin
        rev_ready_o = 1'b1;
        if (rev_done_i) begin
          cnt_step_o = !beat_last_i;
          state_d    = e_rd_beat;
        end
      end
      default: state_d = e_idle;
    endcase
  end

  always_comb begin
    case (state_q)
      e_wr_beat, e_wr_wait, e_wr_resp: cnt_is_wr_o = e_mem_uc_wr;
      e_rd_beat, e_rd_wait:            cnt_is_wr_o = e_mem_uc_rd;
      default: cnt_is_wr_o = aw_valid_i ? e_mem_uc_wr : e_mem_uc_rd; // selects the AX mux.
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= e_idle;
      fin_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (cnt_load_o) begin
        fin_q <= 1'b0;
      end else if (state_q == e_rd_wait && rev_done_i && beat_last_i) begin
        fin_q <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/axi_burst_counter.sv
/* INCR addressing only; no 4 KB boundary check, wrap bursts step linearly. */

`timescale 1ns/1ps

`include "axi_bridge_cfg.svh"

module axi_burst_counter
  import axi_bridge_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   load_i,
  input  axi_ax_s                ax_i,
  input  logic                   step_i,
  output logic [`AXI_ADDR_W-1:0] addr_o,
  output logic [`AXI_ID_W-1:0]   id_o,
  output logic [2:0]             size_o,
  output logic                   last_o
);

  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [`AXI_LEN_W-1:0]  cnt_q;             // beats still to go after this one.
  logic [`AXI_ID_W-1:0]   id_q;
  logic [2:0]             size_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= ax_i.len;
    end else if (step_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // request fields held for the whole burst.
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      addr_q <= ax_i.addr;
      id_q   <= ax_i.id;
      size_q <= ax_i.size;
    end else if (step_i) begin
      addr_q <= addr_q + (`AXI_ADDR_W'(1) << size_q); // next beat.
    end
  end

  assign addr_o = addr_q;
  assign id_o   = id_q;
  assign size_o = size_q;
  assign last_o = (cnt_q == '0);

endmodule

//--- verilog/axi_bridge_pkg.sv
/* shared message and request types; field widths come from the cfg header. */

`include "axi_bridge_cfg.svh"

package axi_bridge_pkg;

  typedef enum logic [0:0] {
    e_mem_uc_rd = 1'b0,                      // uncached read.
    e_mem_uc_wr = 1'b1                       // uncached write.
  } mem_msg_e;

  // forward message, one per AXI beat.
  typedef struct packed {
    mem_msg_e                msg_type;
    logic [`AXI_ADDR_W-1:0]  addr;
    logic [2:0]              size;           // log2 of bytes.
    logic [`AXI_DATA_W-1:0]  data;
    logic [`AXI_STRB_W-1:0]  mask;
  } mem_fwd_s;

  // reverse message, one per forward message.
  typedef struct packed {
    mem_msg_e                msg_type;
    logic [`AXI_DATA_W-1:0]  data;
    logic                    err;            // becomes SLVERR.
  } mem_rev_s;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0]  addr;
    logic [`AXI_ID_W-1:0]    id;
    logic [`AXI_LEN_W-1:0]   len;            // beats minus one.
    logic [2:0]              size;
    logic [1:0]              burst;          // treated as INCR.
  } axi_ax_s;

  typedef enum logic [2:0] {
    e_idle    = 3'd0,
    e_wr_beat = 3'd1,
    e_wr_wait = 3'd2,
    e_wr_resp = 3'd3,
    e_rd_beat = 3'd4,
    e_rd_wait = 3'd5
  } bridge_state_e;

endpackage

//--- verilog/axi_bridge_cfg.svh
/* fixed widths for the AXI to memory-stream bridge; data is 64 bits only,
   and the response codes cover OKAY and SLVERR only. */

`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// AXI address and data.
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_STRB_W 8

// transaction id and burst length fields.
`define AXI_ID_W 4
`define AXI_LEN_W 8

// response codes used on B and R.
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif
